// File: Makefile
# Verilator simulation of the l2 cache testbench

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= l2_cache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: l2_cache.f
+incdir+verilog
verilog/l2_cache_pkg.sv
verilog/l2_array_if.sv
verilog/l2_tag_store.sv
verilog/l2_data_store.sv
verilog/l2_cache_ctrl.sv
verilog/l2_cache.sv
verif/l2_cache_tb.sv

// File: verif/l2_cache_tb.sv
// l2 cache testbench
`default_nettype none

module l2_cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 20;
    localparam int          TIMEOUT    = 200;    // cycles per wait
    localparam logic [31:0] SEED       = 32'he27c_b6d3;
    localparam logic [8:0]  SET        = 9'd5;   // every test line maps here
    localparam logic [16:0] TAGS [5]   = '{17'h00123, 17'h00a01, 17'h00b02, 17'h00c03, 17'h01d04};

    logic         clk;
    logic         reset;
    logic         ic_req;
    logic [31:0]  ic_addr;
    logic         ic_complete;
    logic         dc_req;
    logic         dc_rw;
    logic [31:0]  dc_addr;
    logic [127:0] dc_wd;
    logic         dc_complete;
    logic [511:0] mem_rd = '0;
    logic         mem_complete = 1'b0;
    logic         l2_rdy;
    logic [127:0] rd_word;
    logic         l2_busy;
    logic         l2_miss_stall;
    logic         mem_req;
    logic         mem_rw;
    logic [25:0]  mem_addr;
    logic [511:0] mem_wd;

    logic [31:0]  lcg_state = SEED;
    logic [511:0] mem_lines [logic [25:0]];  // sparse backing memory
    logic [26:0]  mem_log [$];               // {rw, line address} per finished access
    logic [511:0] wd_log;                    // data of the last memory write
    int           mem_wait = -1;
    int           checks = 0;
    int           errors = 0;
    logic [511:0] line_a;                    // expected content of the tag 0 line
    logic [127:0] wdata;

    l2_cache dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // first touch of a line fills it from the lcg
    function automatic logic [511:0] model_line(input logic [25:0] la);
        logic [511:0] fresh;
        if (!mem_lines.exists(la)) begin
            for (int i = 0; i < 16; i++) begin
                fresh[i * 32 +: 32] = lcg_next();
            end
            mem_lines[la] = fresh;
        end
        return mem_lines[la];
    endfunction

    function automatic logic [31:0] make_addr(input logic [16:0] tag, input logic [8:0] index,
                                              input logic [1:0] offset);
        return {tag, index, offset, 4'h0};
    endfunction

    function automatic logic [127:0] word_of(input logic [511:0] line, input int offset);
        return line[offset * 128 +: 128];
    endfunction

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // memory model with a latency of 2 to 4 cycles
    always @(posedge clk) begin
        #2;
        if (mem_complete) begin
            mem_complete = 1'b0;
        end else if (mem_req) begin
            if (mem_wait < 0) begin
                mem_wait = 2 + (mem_log.size() % 3);
            end else if (mem_wait == 0) begin
                if (mem_rw) begin
                    mem_lines[mem_addr] = mem_wd;
                    wd_log = mem_wd;
                end else begin
                    mem_rd = model_line(mem_addr);
                end
                mem_log.push_back({mem_rw, mem_addr});
                mem_complete = 1'b1;
                mem_wait = -1;
            end else begin
                mem_wait--;
            end
        end
    end

    // drives one request from raise to complete starting 2 ns after an edge
    task automatic run_request(input logic from_ic, input logic rw, input logic [31:0] addr,
                               input logic [127:0] wd, output logic [127:0] word,
                               output logic stalled);
        int   cycles;
        logic done;
        if (from_ic) begin
            ic_req  = 1'b1;
            ic_addr = addr;
        end else begin
            dc_req  = 1'b1;
            dc_rw   = rw;
            dc_addr = addr;
            dc_wd   = wd;
        end
        cycles  = 0;
        done    = 1'b0;
        stalled = 1'b0;
        word    = '0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
            stalled |= l2_miss_stall;
            if (l2_rdy) begin
                word = rd_word;
                done = 1'b1;
                check_value("l2_busy", l2_busy, 1'b1);
            end
        end
        if (!done) begin
            errors++;
            $display("timeout: no l2_rdy for address %h", addr);
        end
        if (from_ic) ic_complete = 1'b1;
        else dc_complete = 1'b1;
        @(posedge clk);
        #2;
        if (from_ic) begin
            ic_complete = 1'b0;
            ic_req      = 1'b0;
        end else begin
            dc_complete = 1'b0;
            dc_req      = 1'b0;
        end
        check_value("l2_busy", l2_busy, 1'b0);
    endtask

    task automatic cold_read_miss();
        logic [127:0] word;
        logic         stalled;
        int           n;
        n = mem_log.size();
        run_request(1'b0, 1'b0, make_addr(TAGS[0], SET, 2), '0, word, stalled);
        line_a = model_line({TAGS[0], SET});
        check_value("l2_miss_stall", stalled, 1'b1);
        check_value("mem op count", mem_log.size() - n, 1);
        check_value("mem_addr", mem_log[n], {1'b0, TAGS[0], SET});
        check_value("rd_word", word, word_of(line_a, 2));
    endtask

    task automatic read_hit();
        logic [127:0] word;
        logic         stalled;
        int           n;
        n = mem_log.size();
        run_request(1'b0, 1'b0, make_addr(TAGS[0], SET, 2), '0, word, stalled);
        check_value("rd_word", word, word_of(line_a, 2));
        check_value("l2_miss_stall", stalled, 1'b0);
        run_request(1'b0, 1'b0, make_addr(TAGS[0], SET, 3), '0, word, stalled);
        check_value("rd_word", word, word_of(line_a, 3));
        check_value("l2_miss_stall", stalled, 1'b0);
        check_value("mem op count", mem_log.size() - n, 0);
    endtask

    task automatic write_then_read();
        logic [127:0] word;
        logic         stalled;
        wdata = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        run_request(1'b0, 1'b1, make_addr(TAGS[0], SET, 2), wdata, word, stalled);
        line_a[2 * 128 +: 128] = wdata;
        run_request(1'b1, 1'b0, make_addr(TAGS[0], SET, 2), '0, word, stalled);
        check_value("rd_word", word, wdata);
    endtask

    task automatic ic_priority();
        logic [127:0] word;
        logic         stalled;
        dc_req  = 1'b1;    // raised in the same cycle as the ic side
        dc_rw   = 1'b0;
        dc_addr = make_addr(TAGS[0], SET, 0);
        run_request(1'b1, 1'b0, make_addr(TAGS[0], SET, 2), '0, word, stalled);
        check_value("rd_word", word, wdata);
        run_request(1'b0, 1'b0, make_addr(TAGS[0], SET, 0), '0, word, stalled);
        check_value("rd_word", word, word_of(line_a, 0));
    endtask

    task automatic plru_eviction();
        logic [127:0] word;
        logic         stalled;
        int           n;
        // filling ways 1..3 in order leaves the tree pointing at dirty way 0
        for (int i = 1; i < 4; i++) begin
            run_request(1'b0, 1'b0, make_addr(TAGS[i], SET, 0), '0, word, stalled);
            check_value("rd_word", word, word_of(model_line({TAGS[i], SET}), 0));
        end
        n = mem_log.size();
        run_request(1'b0, 1'b0, make_addr(TAGS[4], SET, 1), '0, word, stalled);
        check_value("mem op count", mem_log.size() - n, 2);
        check_value("mem_addr", mem_log[n], {1'b1, TAGS[0], SET});
        check_value("mem_wd", wd_log, line_a);
        check_value("mem_addr", mem_log[n + 1], {1'b0, TAGS[4], SET});
        check_value("rd_word", word, word_of(model_line({TAGS[4], SET}), 1));
    endtask

    task automatic evicted_line_reread();
        logic [127:0] word;
        logic         stalled;
        int           n;
        n = mem_log.size();
        // tree now picks clean way 2 and skips the writeback
        run_request(1'b0, 1'b0, make_addr(TAGS[0], SET, 2), '0, word, stalled);
        check_value("l2_miss_stall", stalled, 1'b1);
        check_value("mem op count", mem_log.size() - n, 1);
        check_value("mem_addr", mem_log[n], {1'b0, TAGS[0], SET});
        check_value("rd_word", word, wdata);
    endtask

    initial begin
        reset       = 1'b1;
        ic_req      = 1'b0;
        ic_addr     = '0;
        ic_complete = 1'b0;
        dc_req      = 1'b0;
        dc_rw       = 1'b0;
        dc_addr     = '0;
        dc_wd       = '0;
        dc_complete = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        cold_read_miss();
        read_hit();
        write_then_read();
        ic_priority();
        plru_eviction();
        evicted_line_reread();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/l2_array_if.sv
// l2 controller to store link
`default_nettype none

`include "l2_cache_defs.svh"

interface l2_array_if;

    // lookup key, from the latched request
    logic [`L2_INDEX_W-1:0]  index;
    logic [`L2_TAG_W-1:0]    tag;
    logic [`L2_OFFSET_W-1:0] offset;

    logic                    hit;
    l2_cache_pkg::l2_way_t   hit_way;
    l2_cache_pkg::l2_way_t   victim_way;
    logic                    victim_dirty;
    logic [`L2_TAG_W-1:0]    victim_tag;

    logic                    word_we;       // one word into hit_way
    logic [`L2_WORD_W-1:0]   word_wd;
    logic                    fill_we;       // whole line into victim_way
    logic [`L2_LINE_W-1:0]   fill_wd;
    logic                    touch;         // plru update for hit_way

    logic [`L2_WORD_W-1:0]   rd_word;
    logic [`L2_LINE_W-1:0]   victim_line;

    modport ctrl (output index, tag, offset, word_we, word_wd, fill_we, fill_wd, touch,
                  input  hit, hit_way, victim_way, victim_dirty, victim_tag,
                  rd_word, victim_line);
    modport tags (input  index, tag, word_we, fill_we, touch,
                  output hit, hit_way, victim_way, victim_dirty, victim_tag);
    modport data (input  index, offset, hit_way, victim_way, word_we, word_wd, fill_we, fill_wd,
                  output rd_word, victim_line);

endinterface

`default_nettype wire

// File: verilog/l2_cache.sv
// l2 cache top
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ic_req,
    input  wire  [`L2_ADDR_W-1:0]      ic_addr,
    input  wire                        ic_complete,
    input  wire                        dc_req,
    input  wire                        dc_rw,
    input  wire  [`L2_ADDR_W-1:0]      dc_addr,
    input  wire  [`L2_WORD_W-1:0]      dc_wd,
    input  wire                        dc_complete,
    input  wire  [`L2_LINE_W-1:0]      mem_rd,
    input  wire                        mem_complete,
    output logic                       l2_rdy,
    output logic [`L2_WORD_W-1:0]      rd_word,
    output logic                       l2_busy,
    output logic                       l2_miss_stall,
    output logic                       mem_req,
    output logic                       mem_rw,
    output logic [`L2_LINE_ADDR_W-1:0] mem_addr,
    output logic [`L2_LINE_W-1:0]      mem_wd
);

    l2_array_if arr_if ();

    l2_cache_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .ic_req        (ic_req),
        .ic_addr       (ic_addr),
        .ic_complete   (ic_complete),
        .dc_req        (dc_req),
        .dc_rw         (dc_rw),
        .dc_addr       (dc_addr),
        .dc_wd         (dc_wd),
        .dc_complete   (dc_complete),
        .mem_rd        (mem_rd),
        .mem_complete  (mem_complete),
        .l2_rdy        (l2_rdy),
        .rd_word       (rd_word),
        .l2_busy       (l2_busy),
        .l2_miss_stall (l2_miss_stall),
        .mem_req       (mem_req),
        .mem_rw        (mem_rw),
        .mem_addr      (mem_addr),
        .mem_wd        (mem_wd),
        .arr           (arr_if.ctrl)
    );

    l2_tag_store tag_i (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_if.tags)
    );

    l2_data_store data_i (
        .clk (clk),
        .arr (arr_if.data)
    );

endmodule

`default_nettype wire

// File: verilog/l2_cache_ctrl.sv
// l2 cache controller
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ic_req,
    input  wire  [`L2_ADDR_W-1:0]      ic_addr,
    input  wire                        ic_complete,
    input  wire                        dc_req,
    input  wire                        dc_rw,
    input  wire  [`L2_ADDR_W-1:0]      dc_addr,
    input  wire  [`L2_WORD_W-1:0]      dc_wd,
    input  wire                        dc_complete,
    input  wire  [`L2_LINE_W-1:0]      mem_rd,
    input  wire                        mem_complete,
    output logic                       l2_rdy,
    output logic [`L2_WORD_W-1:0]      rd_word,
    output logic                       l2_busy,
    output logic                       l2_miss_stall,
    output logic                       mem_req,
    output logic                       mem_rw,
    output logic [`L2_LINE_ADDR_W-1:0] mem_addr,
    output logic [`L2_LINE_W-1:0]      mem_wd,
    l2_array_if.ctrl                   arr
);

    l2_cache_pkg::l2_state_e state_q;
    l2_cache_pkg::l2_state_e state_d;

    l2_cache_pkg::l2_addr_u req_addr_q;
    logic                   req_rw_q;
    logic [`L2_WORD_W-1:0]  req_wd_q;
    logic                   req_ic_q;     // instruction side granted
    logic                   req_complete;
    logic                   req_seen;
    logic                   in_access;

    assign req_seen     = ic_req || dc_req;
    assign req_complete = req_ic_q ? ic_complete : dc_complete;
    assign in_access    = (state_q == l2_cache_pkg::access);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= l2_cache_pkg::idle;
            req_ic_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == l2_cache_pkg::idle && req_seen) begin
                req_ic_q <= ic_req;  // fixed priority, ic first
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (state_q == l2_cache_pkg::idle && req_seen) begin
            req_addr_q <= ic_req ? ic_addr : dc_addr;
            req_rw_q   <= ic_req ? `L2_READ : dc_rw;  // ic never writes
            req_wd_q   <= dc_wd;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2_cache_pkg::idle: begin
                if (req_seen) state_d = l2_cache_pkg::access;
            end
            l2_cache_pkg::access: begin
                if (arr.hit) begin
                    if (req_complete) state_d = l2_cache_pkg::idle;
                end else if (arr.victim_dirty) begin
                    state_d = l2_cache_pkg::write_mem;
                end else begin
                    state_d = l2_cache_pkg::refill;
                end
            end
            l2_cache_pkg::write_mem: begin
                if (mem_complete) state_d = l2_cache_pkg::refill;
            end
            l2_cache_pkg::refill: begin
                if (mem_complete) state_d = l2_cache_pkg::access;  // retry the lookup
            end
            default: state_d = l2_cache_pkg::idle;
        endcase
    end

    assign arr.index  = req_addr_q.fields.index;
    assign arr.tag    = req_addr_q.fields.tag;
    assign arr.offset = req_addr_q.fields.offset;

    // hit side
    assign l2_rdy      = in_access && arr.hit;
    assign rd_word     = arr.rd_word;
    assign arr.touch   = l2_rdy && req_complete;
    assign arr.word_we = l2_rdy && req_complete && (req_rw_q == `L2_WRITE);
    assign arr.word_wd = req_wd_q;

    // miss side
    assign arr.fill_we = (state_q == l2_cache_pkg::refill) && mem_complete;
    assign arr.fill_wd = mem_rd;

    assign mem_req  = (state_q == l2_cache_pkg::write_mem) || (state_q == l2_cache_pkg::refill);
    assign mem_rw   = (state_q == l2_cache_pkg::write_mem) ? `L2_WRITE : `L2_READ;
    assign mem_addr = (state_q == l2_cache_pkg::write_mem) ? {arr.victim_tag, arr.index}
                                                             : req_addr_q.line.line;
    assign mem_wd   = arr.victim_line;

    assign l2_busy       = (state_q != l2_cache_pkg::idle);
    assign l2_miss_stall = (in_access && !arr.hit) || mem_req;  // held until retry hits

endmodule

`default_nettype wire

// File: verilog/l2_cache_defs.svh
// l2 cache geometry and codes
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// address split
`define L2_ADDR_W        32
`define L2_TAG_W         17
`define L2_INDEX_W       9
`define L2_OFFSET_W      2    // word within line
`define L2_BYTE_W        4    // byte within word
`define L2_LINE_ADDR_W   26
`define L2_LINE_BYTE_W   6

// storage
`define L2_WORD_W        128
`define L2_LINE_W        512
`define L2_WAYS          4
`define L2_WAY_W         2
`define L2_SETS          512
`define L2_PLRU_W        3    // tree bits per set

// rw level, dc and memory sides
`define L2_READ          1'b0
`define L2_WRITE         1'b1

// controller state codes
`define L2_ST_IDLE       2'd0
`define L2_ST_ACCESS     2'd1
`define L2_ST_WRITE_MEM  2'd2
`define L2_ST_REFILL     2'd3

`endif

// File: verilog/l2_cache_pkg.sv
// l2 cache shared types
`default_nettype none

`include "l2_cache_defs.svh"

package l2_cache_pkg;

    // tag / set / word / byte split of a request
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [`L2_BYTE_W-1:0]   byte_sel;
    } l2_addr_fields_t;

    // same address seen as a memory line number
    typedef struct packed {
        logic [`L2_LINE_ADDR_W-1:0] line;
        logic [`L2_LINE_BYTE_W-1:0] line_byte;
    } l2_addr_line_t;

    typedef union packed {
        l2_addr_fields_t fields;
        l2_addr_line_t   line;
    } l2_addr_u;

    typedef logic [`L2_WAY_W-1:0] l2_way_t;

    typedef enum logic [1:0] {
        idle      = `L2_ST_IDLE,
        access    = `L2_ST_ACCESS,
        write_mem = `L2_ST_WRITE_MEM,  // dirty victim going out
        refill    = `L2_ST_REFILL
    } l2_state_e;

endpackage

`default_nettype wire

// File: verilog/l2_data_store.sv
// l2 line data store
`default_nettype none

`include "l2_cache_defs.svh"

module l2_data_store (
    input  wire       clk,
    l2_array_if.data  arr
);

    logic [`L2_LINE_W-1:0] line_mem [`L2_WAYS][`L2_SETS];

    logic [`L2_LINE_W-1:0] hit_line;

    assign hit_line        = line_mem[arr.hit_way][arr.index];
    assign arr.victim_line = line_mem[arr.victim_way][arr.index];  // writeback source

    // word select by offset
    always_comb begin
        case (arr.offset)
            2'd0:    arr.rd_word = hit_line[0 * `L2_WORD_W +: `L2_WORD_W];
            2'd1:    arr.rd_word = hit_line[1 * `L2_WORD_W +: `L2_WORD_W];
            2'd2:    arr.rd_word = hit_line[2 * `L2_WORD_W +: `L2_WORD_W];
            default: arr.rd_word = hit_line[3 * `L2_WORD_W +: `L2_WORD_W];
        endcase
    end

    // refill replaces the line, a write hit patches one word
    always_ff @(posedge clk) begin
        if (arr.fill_we) begin
            line_mem[arr.victim_way][arr.index] <= arr.fill_wd;
        end else if (arr.word_we) begin
            case (arr.offset)
                2'd0: line_mem[arr.hit_way][arr.index][0 * `L2_WORD_W +: `L2_WORD_W]
                          <= arr.word_wd;
                2'd1: line_mem[arr.hit_way][arr.index][1 * `L2_WORD_W +: `L2_WORD_W]
                          <= arr.word_wd;
                2'd2: line_mem[arr.hit_way][arr.index][2 * `L2_WORD_W +: `L2_WORD_W]
                          <= arr.word_wd;
                default: line_mem[arr.hit_way][arr.index][3 * `L2_WORD_W +: `L2_WORD_W]
                          <= arr.word_wd;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/l2_tag_store.sv
// l2 tag, state and plru store
`default_nettype none

`include "l2_cache_defs.svh"

module l2_tag_store (
    input  wire       clk,
    input  wire       reset,
    l2_array_if.tags  arr
);

    logic [`L2_TAG_W-1:0]  tag_mem [`L2_WAYS][`L2_SETS];
    logic [`L2_WAYS-1:0]   valid_q [`L2_SETS];
    logic [`L2_WAYS-1:0]   dirty_q [`L2_SETS];
    logic [`L2_PLRU_W-1:0] plru_q  [`L2_SETS];

    logic [`L2_WAYS-1:0]   set_valid;
    logic [`L2_WAYS-1:0]   set_dirty;
    logic [`L2_PLRU_W-1:0] plru;
    logic [`L2_PLRU_W-1:0] plru_next;
    l2_cache_pkg::l2_way_t plru_way;
    logic                  any_invalid;

    assign set_valid = valid_q[arr.index];
    assign set_dirty = dirty_q[arr.index];
    assign plru      = plru_q[arr.index];

    // hit compare, lowest way wins
    always_comb begin
        arr.hit     = 1'b0;
        arr.hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (set_valid[w] && tag_mem[w][arr.index] == arr.tag) begin
                arr.hit     = 1'b1;
                arr.hit_way = l2_cache_pkg::l2_way_t'(w);
            end
        end
    end

    // tree walk, bit 0 picks the half
    always_comb begin
        if (!plru[0]) begin
            plru_way = plru[1] ? 2'd1 : 2'd0;
        end else begin
            plru_way = plru[2] ? 2'd3 : 2'd2;
        end
    end

    // first invalid way, else plru
    always_comb begin
        any_invalid    = 1'b0;
        arr.victim_way = plru_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                any_invalid    = 1'b1;
                arr.victim_way = l2_cache_pkg::l2_way_t'(w);
            end
        end
    end

    assign arr.victim_dirty = !any_invalid && set_dirty[arr.victim_way];
    assign arr.victim_tag   = tag_mem[arr.victim_way][arr.index];

    // point the tree away from the touched way
    always_comb begin
        case (arr.hit_way)
            2'd0:    plru_next = {plru[2], 1'b1, 1'b1};
            2'd1:    plru_next = {plru[2], 1'b0, 1'b1};
            2'd2:    plru_next = {1'b1, plru[1], 1'b0};
            default: plru_next = {1'b0, plru[1], 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (arr.fill_we) begin
            tag_mem[arr.victim_way][arr.index] <= arr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (arr.fill_we) begin
                valid_q[arr.index][arr.victim_way] <= 1'b1;
                dirty_q[arr.index][arr.victim_way] <= 1'b0;  // clean copy of memory
            end
            if (arr.word_we) begin
                dirty_q[arr.index][arr.hit_way] <= 1'b1;
            end
            if (arr.touch) begin
                plru_q[arr.index] <= plru_next;
            end
        end
    end

endmodule

`default_nettype wire
